/* rtl/execCore_consts.svh */
// execute slice widths shared by the packages and the RTL
`ifndef EXEC_CORE_CONSTS_SVH
`define EXEC_CORE_CONSTS_SVH

// register and datapath width
`define DATA_WIDTH 16

// number of architectural registers, r0 included
`define REG_COUNT 16

// width of a register index field in the instruction word
`define REG_IDX_WIDTH 4

`endif

/* rtl/isaPkg.sv */
// instruction set types: opcodes and the two instruction word layouts
`include "execCore_consts.svh"

package isaPkg;

  typedef enum logic [3:0] {
    opAdd = 4'd0,
    opSub = 4'd1,
    opXor = 4'd2,
    opAnd = 4'd3,
    opSll = 4'd4,
    opSra = 4'd5,
    opRor = 4'd6,
    opLlb = 4'd7,
    opLhb = 4'd8
  } opcodeT;

  // arithmetic, logic and shifts; rt doubles as the shift amount
  typedef struct packed {
    opcodeT                    opcode;
    logic [`REG_IDX_WIDTH-1:0] rd;
    logic [`REG_IDX_WIDTH-1:0] rs;
    logic [`REG_IDX_WIDTH-1:0] rt;
  } regFormT;

  // byte loads
  typedef struct packed {
    opcodeT                    opcode;
    logic [`REG_IDX_WIDTH-1:0] rd;
    logic [7:0]                imm8;
  } byteFormT;

  typedef union packed {
    regFormT  regForm;
    byteFormT byteForm;
  } instrT;

endpackage

/* rtl/aluPkg.sv */
// ALU operation codes and condition flags
package aluPkg;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluXor,
    aluAnd,
    aluSll,
    aluSra,
    aluRor,
    aluLlb,
    aluLhb
  } aluOpT;

  // z zero, v saturation, n negative
  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flagsT;

endpackage

/* rtl/regFile.sv */
// two-read one-write register file with a hard-wired zero register
`timescale 1ns/1ps
`include "execCore_consts.svh"

module regFile (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic [`REG_IDX_WIDTH-1:0] srcReg1,
  input  logic [`REG_IDX_WIDTH-1:0] srcReg2,
  input  logic [`REG_IDX_WIDTH-1:0] dstReg,
  input  logic                      writeReg,
  input  logic [`DATA_WIDTH-1:0]    dstData,
  output logic [`DATA_WIDTH-1:0]    srcData1,
  output logic [`DATA_WIDTH-1:0]    srcData2
);

  logic [`REG_COUNT-1:0] writeLine;
  logic [`REG_COUNT-1:0] readLine1;
  logic [`REG_COUNT-1:0] readLine2;

  // r0 has no storage
  logic [`DATA_WIDTH-1:0] regs [1:`REG_COUNT-1];

  // one-hot row select from a register index
  function automatic logic [`REG_COUNT-1:0] decodeRow(
    input logic [`REG_IDX_WIDTH-1:0] idx
  );
    logic [`REG_COUNT-1:0] row;
    row = '0;
    row[idx] = 1'b1;
    return row;
  endfunction

  assign writeLine = writeReg ? decodeRow(dstReg) : '0;
  assign readLine1 = decodeRow(srcReg1);
  assign readLine2 = decodeRow(srcReg2);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // row 0 enable is simply dropped
      for (int i = 1; i < `REG_COUNT; i++) begin
        if (writeLine[i]) begin
          regs[i] <= dstData;
        end
      end
    end
  end

  // each port ORs the one selected row, so a hit on row 0 leaves zero
  always_comb begin
    srcData1 = '0;
    srcData2 = '0;
    for (int i = 1; i < `REG_COUNT; i++) begin
      if (readLine1[i]) begin
        srcData1 = srcData1 | regs[i];
      end
      if (readLine2[i]) begin
        srcData2 = srcData2 | regs[i];
      end
    end
  end

endmodule

/* rtl/instrDecoder.sv */
// instruction decoder: register indices, ALU operation, immediate and write enable
`timescale 1ns/1ps
`include "execCore_consts.svh"

module instrDecoder (
  input  isaPkg::instrT              instr,
  input  logic                       instrValid,
  output logic [`REG_IDX_WIDTH-1:0]  srcReg1,
  output logic [`REG_IDX_WIDTH-1:0]  srcReg2,
  output logic [`REG_IDX_WIDTH-1:0]  dstReg,
  output logic                       writeReg,
  output aluPkg::aluOpT              aluOp,
  output logic [7:0]                 imm,
  output logic                       setsNv
);

  logic defined;
  logic [7:0] shiftImm;

  // shift amount lives in rt, zero-extended into the byte immediate
  assign shiftImm = {{(8 - `REG_IDX_WIDTH){1'b0}}, instr.regForm.rt};

  always_comb begin
    srcReg1 = instr.regForm.rs;
    srcReg2 = instr.regForm.rt;
    dstReg  = instr.regForm.rd;
    aluOp   = aluPkg::aluAdd;
    imm     = '0;
    setsNv  = 1'b0;
    defined = 1'b1;

    case (instr.regForm.opcode)
      isaPkg::opAdd: begin
        aluOp  = aluPkg::aluAdd;
        setsNv = 1'b1;
      end
      isaPkg::opSub: begin
        aluOp  = aluPkg::aluSub;
        setsNv = 1'b1;
      end
      isaPkg::opXor: aluOp = aluPkg::aluXor;
      isaPkg::opAnd: aluOp = aluPkg::aluAnd;
      isaPkg::opSll: begin
        aluOp = aluPkg::aluSll;
        imm   = shiftImm;
      end
      isaPkg::opSra: begin
        aluOp = aluPkg::aluSra;
        imm   = shiftImm;
      end
      isaPkg::opRor: begin
        aluOp = aluPkg::aluRor;
        imm   = shiftImm;
      end
      // byte loads read rd back so the other byte survives
      isaPkg::opLlb: begin
        aluOp   = aluPkg::aluLlb;
        srcReg1 = instr.byteForm.rd;
        imm     = instr.byteForm.imm8;
      end
      isaPkg::opLhb: begin
        aluOp   = aluPkg::aluLhb;
        srcReg1 = instr.byteForm.rd;
        imm     = instr.byteForm.imm8;
      end
      default: defined = 1'b0;
    endcase

    writeReg = instrValid & defined;
  end

endmodule

/* rtl/alu.sv */
// 16-bit ALU with saturating add/sub, logic, shifts, byte loads and flags
`timescale 1ns/1ps
`include "execCore_consts.svh"

module alu (
  input  aluPkg::aluOpT           aluOp,
  input  logic [`DATA_WIDTH-1:0]  srcData1,
  input  logic [`DATA_WIDTH-1:0]  srcData2,
  input  logic [7:0]              imm,
  output logic [`DATA_WIDTH-1:0]  value,
  output aluPkg::flagsT           flagsOut
);

  logic [`DATA_WIDTH-1:0]   sum;
  logic [`DATA_WIDTH-1:0]   diff;
  logic                     sumOvf;
  logic                     diffOvf;
  logic [`DATA_WIDTH-1:0]   satPos;
  logic [`DATA_WIDTH-1:0]   satNeg;
  logic [3:0]               shamt;
  logic [2*`DATA_WIDTH-1:0] rotPair;
  logic                     sat;

  assign satPos = {1'b0, {(`DATA_WIDTH-1){1'b1}}};
  assign satNeg = {1'b1, {(`DATA_WIDTH-1){1'b0}}};

  assign sum  = srcData1 + srcData2;
  assign diff = srcData1 - srcData2;

  // overflow when the sign of the result disagrees with the operands
  assign sumOvf  = (srcData1[`DATA_WIDTH-1] == srcData2[`DATA_WIDTH-1]) &&
                   (sum[`DATA_WIDTH-1] != srcData1[`DATA_WIDTH-1]);
  assign diffOvf = (srcData1[`DATA_WIDTH-1] != srcData2[`DATA_WIDTH-1]) &&
                   (diff[`DATA_WIDTH-1] != srcData1[`DATA_WIDTH-1]);

  assign shamt   = imm[3:0];
  assign rotPair = {srcData1, srcData1} >> shamt;

  always_comb begin
    sat   = 1'b0;
    value = '0;
    case (aluOp)
      aluPkg::aluAdd: begin
        sat   = sumOvf;
        value = sumOvf ? (srcData1[`DATA_WIDTH-1] ? satNeg : satPos) : sum;
      end
      aluPkg::aluSub: begin
        sat   = diffOvf;
        value = diffOvf ? (srcData1[`DATA_WIDTH-1] ? satNeg : satPos) : diff;
      end
      aluPkg::aluXor: value = srcData1 ^ srcData2;
      aluPkg::aluAnd: value = srcData1 & srcData2;
      aluPkg::aluSll: value = srcData1 << shamt;
      aluPkg::aluSra: value = $signed(srcData1) >>> shamt;
      aluPkg::aluRor: value = rotPair[`DATA_WIDTH-1:0];
      aluPkg::aluLlb: value = {srcData1[`DATA_WIDTH-1:8], imm};
      aluPkg::aluLhb: value = {imm, srcData1[7:0]};
      default:        value = '0;
    endcase

    flagsOut.z = (value == '0);
    flagsOut.v = sat;
    flagsOut.n = value[`DATA_WIDTH-1];
  end

endmodule

/* rtl/execCore.sv */
// execute slice top: decode, register read, ALU, write-back, result and flag registers
`timescale 1ns/1ps
`include "execCore_consts.svh"

module execCore (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic [`DATA_WIDTH-1:0]  instr,
  input  logic                    instrValid,
  output logic [`DATA_WIDTH-1:0]  result,
  output logic                    resultValid,
  output aluPkg::flagsT           flags
);

  logic [`REG_IDX_WIDTH-1:0] srcReg1;
  logic [`REG_IDX_WIDTH-1:0] srcReg2;
  logic [`REG_IDX_WIDTH-1:0] dstReg;
  logic                      writeReg;
  aluPkg::aluOpT             aluOp;
  logic [7:0]                imm;
  logic                      setsNv;
  logic [`DATA_WIDTH-1:0]    srcData1;
  logic [`DATA_WIDTH-1:0]    srcData2;
  logic [`DATA_WIDTH-1:0]    aluValue;
  aluPkg::flagsT             aluFlags;

  instrDecoder decoder (
    .instr      (isaPkg::instrT'(instr)),
    .instrValid (instrValid),
    .srcReg1    (srcReg1),
    .srcReg2    (srcReg2),
    .dstReg     (dstReg),
    .writeReg   (writeReg),
    .aluOp      (aluOp),
    .imm        (imm),
    .setsNv     (setsNv)
  );

  regFile regs (
    .clk      (clk),
    .arstN    (arstN),
    .srcReg1  (srcReg1),
    .srcReg2  (srcReg2),
    .dstReg   (dstReg),
    .writeReg (writeReg),
    .dstData  (aluValue),
    .srcData1 (srcData1),
    .srcData2 (srcData2)
  );

  alu alu (
    .aluOp    (aluOp),
    .srcData1 (srcData1),
    .srcData2 (srcData2),
    .imm      (imm),
    .value    (aluValue),
    .flagsOut (aluFlags)
  );

  // writeReg already folds in the strobe and a defined opcode
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      result      <= '0;
      resultValid <= 1'b0;
      flags       <= '0;
    end else begin
      resultValid <= instrValid;
      if (instrValid) begin
        result <= writeReg ? aluValue : '0;
      end
      if (writeReg) begin
        flags.z <= aluFlags.z;
        // n and v only move on add and sub
        if (setsNv) begin
          flags.v <= aluFlags.v;
          flags.n <= aluFlags.n;
        end
      end
    end
  end

endmodule

/* test/execCoreTb.sv */
// testbench for the execute slice, replays the instruction trace and checks result and flags
`timescale 1ns/1ps
`include "execCore_consts.svh"

module execCoreTb;

  localparam int MAX_ENTRIES  = 64;
  localparam int RESET_CYCLES = 10;
  localparam int CLK_HALF     = 20;

  logic                   clk;
  logic                   arstN;
  logic [`DATA_WIDTH-1:0] instr;
  logic                   instrValid;
  logic [`DATA_WIDTH-1:0] result;
  logic                   resultValid;
  aluPkg::flagsT          flags;

  // three words per entry: instruction, expected result, expected flags
  logic [`DATA_WIDTH-1:0] traceMem [0:3*MAX_ENTRIES-1];

  int          numEntries    = 0;
  int          cycleLimit    = 0;
  int          cycleCount    = 0;
  int          issuedCount   = 0;
  int          nextIdx       = 0;
  int          resultCount   = 0;
  int          driverErrors  = 0;
  int          driverChecks  = 0;
  int          monitorErrors = 0;
  int          monitorChecks = 0;
  logic [31:0] rngState;
  logic        lastStrobe;

  execCore uut (
    .clk         (clk),
    .arstN       (arstN),
    .instr       (instr),
    .instrValid  (instrValid),
    .result      (result),
    .resultValid (resultValid),
    .flags       (flags)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // entries end at the first row whose flags word is all ones
  task automatic loadTrace();
    $readmemh("test/execTrace.txt", traceMem);
    numEntries = 0;
    while (numEntries < MAX_ENTRIES && traceMem[3*numEntries+2] != '1) begin
      numEntries++;
    end
  endtask

  task automatic printCounts();
    $display("Checks: %0d, results: %0d of %0d, errors: %0d",
             driverChecks + monitorChecks, resultCount, numEntries,
             driverErrors + monitorErrors);
  endtask

  // what the DUT sampled on instrValid at the last rising edge
  always @(posedge clk) begin
    lastStrobe <= instrValid;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      printCounts();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // outputs are sampled at the falling edge, half a cycle after they change
  always @(negedge clk) begin
    logic [`DATA_WIDTH-1:0] expResult;
    logic [2:0]             expFlags;
    if (arstN === 1'b1) begin
      monitorChecks++;
      assert (resultValid == lastStrobe) else begin
        monitorErrors++;
        if (resultValid) begin
          $display("Unexpected resultValid at time %0t, nothing was strobed the cycle before",
                   $time);
        end else begin
          $display("Missing resultValid at time %0t after a strobed instruction", $time);
        end
      end
      if (resultValid || lastStrobe) begin
        assert (nextIdx < issuedCount) else begin
          monitorErrors++;
          $display("resultValid at time %0t with no instruction pending", $time);
        end
        if (nextIdx < issuedCount) begin
          if (resultValid) begin
            expResult = traceMem[3*nextIdx+1];
            expFlags  = traceMem[3*nextIdx+2][2:0];
            monitorChecks += 2;
            assert (result == expResult) else begin
              monitorErrors++;
              $display("[FAIL] %0t: entry %0d instr %h result expected %h got %h",
                       $time, nextIdx, traceMem[3*nextIdx], expResult, result);
            end
            assert (flags == expFlags) else begin
              monitorErrors++;
              $display("[FAIL] %0t: entry %0d instr %h flags zvn expected %b got %b",
                       $time, nextIdx, traceMem[3*nextIdx], expFlags, flags);
            end
            resultCount++;
          end
          nextIdx++;
        end
      end
    end
  end

  initial begin
    int gap;
    instr      = '0;
    instrValid = 1'b0;
    arstN      = 1'b0;
    rngState   = 32'd75;
    loadTrace();
    assert (numEntries > 0) else begin
      driverErrors++;
      $display("No entries could be read from test/execTrace.txt");
    end
    // worst case per entry is three idle cycles and the strobe
    cycleLimit = RESET_CYCLES + 4 * numEntries + 20;

    repeat (RESET_CYCLES) @(posedge clk);
    arstN <= 1'b1;

    @(negedge clk);
    driverChecks++;
    assert (!resultValid && flags == '0 && result == '0) else begin
      driverErrors++;
      $display("[FAIL] %0t: after reset expected valid 0 result 0000 flags 000, got %b %h %b",
               $time, resultValid, result, flags);
    end

    for (int i = 0; i < numEntries; i++) begin
      rngState = xorshift32(rngState);
      gap = int'(rngState % 32'd4);
      repeat (gap) begin
        @(posedge clk);
        instrValid <= 1'b0;
        instr      <= '0;
      end
      @(posedge clk);
      instr      <= traceMem[3*i];
      instrValid <= 1'b1;
      issuedCount++;
    end
    @(posedge clk);
    instrValid <= 1'b0;
    instr      <= '0;

    while (nextIdx < numEntries) @(negedge clk);
    // one more checked falling edge so that a stray pulse is still caught
    repeat (2) @(posedge clk);

    driverChecks++;
    assert (resultCount == numEntries) else begin
      driverErrors++;
      $display("Only %0d of %0d results arrived", resultCount, numEntries);
    end

    printCounts();
    if (driverErrors + monitorErrors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+rtl
rtl/isaPkg.sv
rtl/aluPkg.sv
rtl/regFile.sv
rtl/instrDecoder.sv
rtl/alu.sv
rtl/execCore.sv
test/execCoreTb.sv

/* Makefile */
# Verilator build and run for the execute slice testbench

VERILATOR := verilator
TOP       := execCoreTb
FILELIST  := build.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
TRACE     := test/execTrace.txt
PASS_MSG  := Simulation finished: PASS

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN) $(TRACE)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "$(TOP): simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

/* test/execTrace.txt */
// columns: instruction word, expected result, expected flags {z,v,n} in bits 2..0
// a row whose flags column is ffff ends the trace
// reset state, every register reads as zero
0123 0000 4
1456 0000 4
// byte loads build constants, lhb keeps the low byte
7134 0034 0
8112 1234 0
0210 1234 0
73ff 00ff 0
8380 80ff 0
0430 80ff 1
// register 0 ignores writes, undefined opcodes leave flags alone
7055 0055 1
0500 0000 4
9123 0000 4
f456 0000 4
// saturating add and subtract
76ff 00ff 0
867f 7fff 0
7701 0001 0
0867 7fff 2
8980 8000 2
0a99 8000 3
1b97 8000 3
1c69 7fff 2
a000 0000 2
1d76 8002 1
0ed7 8003 1
1f77 0000 4
1f07 ffff 1
// logic and shifts, n and v stay from the last add or sub
2513 92cb 1
3513 0034 1
3610 0000 5
4714 2340 1
5844 f80f 1
5923 0246 1
6a14 4123 1
6b48 ff80 1
4c4f 8000 1
4d1f 0000 5
// dependent chain through r1, r2 and r3
7101 1201 1
0111 2402 0
0111 4804 0
0111 7fff 2
1211 0000 4
2221 7fff 0
532e 0001 0
0332 7fff 2
c3ff 0000 2
2444 0000 6
// end marker
0000 0000 ffff
